/* files.f */
verilog/bbox_pkg.sv
verilog/pixel_coord_counter.sv
verilog/frame_config.sv
verilog/bbox_accumulator.sv
verilog/bbox_overlay.sv
verilog/bbox_highlight_top.sv
tb/bbox_highlight_asserts.sv
tb/bbox_highlight_tb.sv

/* tb/bbox_highlight_asserts.sv */
/*
 * Concurrent checks bound into the highlight top level
 * Output valid latency, ordering of the published box, column range
 */

`timescale 1ns/100ps

module bbox_highlight_asserts
	import bbox_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     pixel_valid_i,                // Input beat
	input logic     pixel_valid_o,                // Output beat
	input coord_x_t x_i,                          // Column from the counter
	input coord_x_t line_width_i,                 // Width in force
	input logic     box_active_i,                 // Published box valid
	input coord_x_t box_min_x_i,
	input coord_x_t box_max_x_i,
	input coord_y_t box_min_y_i,
	input coord_y_t box_max_y_i
);

	int fail_count = 0;                             // Read by the testbench at the end

	// Output beat one cycle after every input beat, never otherwise
	valid_latency: assert property (@(posedge clk) disable iff (rst)
		pixel_valid_o == $past(pixel_valid_i))
	else begin
		$error("pixel_valid_o does not follow pixel_valid_i by one cycle");
		fail_count++;
	end

	// Active box is never inverted
	box_ordered: assert property (@(posedge clk) disable iff (rst)
		box_active_i |-> (box_min_x_i <= box_max_x_i) && (box_min_y_i <= box_max_y_i))
	else begin
		$error("published box has a min bound above its max bound");
		fail_count++;
	end

	column_range: assert property (@(posedge clk) disable iff (rst)
		x_i < line_width_i)                       // Wrap happens at width minus 1
	else begin
		$error("column counter reached the active line width");
		fail_count++;
	end

endmodule : bbox_highlight_asserts

// ----------------------------------------------------------------------------
// Attach to every instance of the top level
// ----------------------------------------------------------------------------
bind bbox_highlight_top bbox_highlight_asserts bbox_highlight_asserts_inst (
	.clk           (clk),
	.rst           (rst),
	.pixel_valid_i (pixel_valid_i),
	.pixel_valid_o (pixel_valid_o),
	.x_i           (x),
	.line_width_i  (line_width),
	.box_active_i  (box_active),
	.box_min_x_i   (box_min_x),
	.box_max_x_i   (box_max_x),
	.box_min_y_i   (box_min_y),
	.box_max_y_i   (box_max_y)
);

/* tb/bbox_highlight_tb.sv */
/*
 * Testbench for the motion bounding box highlight
 * Seeded random frames with gaps and sparse motion, a reference model
 * of configuration and published box, output checked per beat
 */

`timescale 1ns/100ps

module bbox_highlight_tb
	import bbox_pkg::*;
();

	logic     clk;
	logic     rst;
	logic     pixel_valid_i;
	logic     motion_i;
	logic     last_i;
	pixel_t   rgb_i;
	coord_x_t width_i;
	pixel_t   highlight_i;
	pixel_t   pixel_o;
	logic     pixel_valid_o;

	// Reference model state
	int       cur_width;                            // Width of the frame being sent
	pixel_t   cur_highlight;                        // Colour of the frame being sent
	int       req_width;                            // Presented on width_i
	pixel_t   req_highlight;                        // Presented on highlight_i
	bit       pub_active;                           // Box used by the current frame
	int       pub_min_x, pub_max_x, pub_min_y, pub_max_y;
	bit       acc_active;                           // Box grown by the current frame
	int       acc_min_x, acc_max_x, acc_min_y, acc_max_y;

	pixel_t   exp_q[$];                             // Expected output pixels
	pixel_t   exp_pix;
	logic     prev_valid;                           // pixel_valid_i one cycle back
	int       errors, checks, tests_run, tests_failed, assert_fails;
	int       rows_plan[12];                        // Row count of each frame
	int       frame_idx, total_beats, new_width, err_mark;
	int unsigned seed;

	bbox_highlight_top bbox_highlight_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;                     // 100 ns period
	end

	// Ends the run if the planned beats take more than twice their cycles
	initial begin
		wait (total_beats > 0);
		#((total_beats * 2 + 16 + 100) * 100);
		$display("Timeout: the DUT did not get through the planned frames in time");
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Model helpers
	// ------------------------------------------------------------------------
	function automatic bit on_outline(input int x, input int y);
		bit vert;
		bit horz;
		vert = (x == pub_min_x || x == pub_max_x) && y >= pub_min_y && y <= pub_max_y;
		horz = (y == pub_min_y || y == pub_max_y) && x >= pub_min_x && x <= pub_max_x;
		return pub_active && (vert || horz);
	endfunction

	task automatic idle_cycle();
		@(posedge clk);
		pixel_valid_i <= 1'b0;
		motion_i      <= 1'($urandom_range(1));   // Must be ignored without valid
		last_i        <= 1'($urandom_range(1));
		rgb_i         <= $urandom();
	endtask

	// One beat on the inputs, model moves with it
	task automatic send_beat(input int x, input int y, input bit mot, input bit last);
		pixel_t rgb;
		rgb = $urandom();
		@(posedge clk);
		pixel_valid_i <= 1'b1;
		motion_i      <= mot;
		last_i        <= last;
		rgb_i         <= rgb;
		width_i       <= coord_x_t'(req_width);
		highlight_i   <= req_highlight;
		exp_q.push_back(on_outline(x, y) ? cur_highlight : rgb);
		if (mot) begin                            // First hit sets, later hits widen
			acc_min_x  = (!acc_active || x < acc_min_x) ? x : acc_min_x;
			acc_max_x  = (!acc_active || x > acc_max_x) ? x : acc_max_x;
			acc_min_y  = (!acc_active || y < acc_min_y) ? y : acc_min_y;
			acc_max_y  = (!acc_active || y > acc_max_y) ? y : acc_max_y;
			acc_active = 1'b1;
		end
		if (last) begin                           // Hand over box and settings
			pub_active    = acc_active;
			pub_min_x     = acc_min_x;
			pub_max_x     = acc_max_x;
			pub_min_y     = acc_min_y;
			pub_max_y     = acc_max_y;
			acc_active    = 1'b0;
			cur_width     = req_width;
			cur_highlight = req_highlight;
		end
	endtask

	// Frame of width times planned rows; one motion pixel or scattered ones
	task automatic run_frame(input bit single, input int scatter_pct, input int gap_pct);
		int rows;
		int width;
		int sx;
		int sy;
		bit last;
		bit mot;
		rows  = rows_plan[frame_idx];
		width = cur_width;                          // Fixed for the whole frame
		frame_idx++;
		sx = $urandom_range(width - 1);
		sy = $urandom_range(rows - 1);
		for (int y = 0; y < rows; y++) begin
			for (int x = 0; x < width; x++) begin
				if ($urandom_range(99) < gap_pct)
					idle_cycle();
				last = (y == rows - 1) && (x == width - 1);
				if (single)
					mot = (x == sx) && (y == sy);
				else
					mot = ($urandom_range(99) < scatter_pct) || (last && scatter_pct > 0);
				send_beat(x, y, mot, last);
			end
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		repeat (2) idle_cycle();                    // Last beat reaches the output
		tests_run++;
		if (errors == mark) begin
			$display("Test %0d (%s) passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d (%s) failed with %0d errors", tests_run, name, errors - mark);
		end
	endtask

	// ------------------------------------------------------------------------
	// Output checks sampled away from the rising edge
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (!rst) begin
			assert (pixel_valid_o === prev_valid) else begin
				$display("error %0t: pixel_valid_o is %b, expected %b", $time,
					pixel_valid_o, prev_valid);
				errors++;
			end
			if (pixel_valid_o === 1'b1) begin
				assert (exp_q.size() > 0) else begin
					$display("Output beat at %0t has no input beat to match it", $time);
					errors++;
				end
				if (exp_q.size() > 0) begin
					exp_pix = exp_q.pop_front();
					checks++;
					assert (pixel_o === exp_pix) else begin
						$display("error %0t: pixel_o is %h, expected %h", $time, pixel_o, exp_pix);
						errors++;
					end
				end
			end
		end
		prev_valid = pixel_valid_i;
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		seed = 32'h01bf72c9;
		void'($urandom(seed));
		rst           = 1'b1;
		pixel_valid_i = 1'b0;
		motion_i      = 1'b0;
		last_i        = 1'b0;
		rgb_i         = '0;
		width_i       = DEFAULT_WIDTH;
		highlight_i   = DEFAULT_HIGHLIGHT;
		prev_valid    = 1'b0;
		cur_width     = DEFAULT_WIDTH;
		req_width     = DEFAULT_WIDTH;
		cur_highlight = DEFAULT_HIGHLIGHT;
		req_highlight = DEFAULT_HIGHLIGHT;
		pub_active    = 1'b0;
		acc_active    = 1'b0;
		for (int i = 0; i < 12; i++)
			rows_plan[i] = $urandom_range(6, 2);
		new_width = $urandom_range(24, 4);
		for (int i = 0; i < 12; i++)               // Last two frames use the new width
			total_beats += rows_plan[i] * ((i < 10) ? DEFAULT_WIDTH : new_width);
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		err_mark = errors;
		run_frame(0, 15, 0);                        // No box yet after reset
		run_frame(0, 0, 0);
		run_frame(0, 0, 0);                         // Follows a motion-free frame
		finish_test("reset and motion-free frames", err_mark);

		err_mark = errors;
		run_frame(1, 0, 0);
		run_frame(0, 0, 0);
		finish_test("single motion pixel", err_mark);

		err_mark = errors;
		run_frame(0, 8, 0);
		run_frame(0, 0, 0);
		finish_test("scattered motion outline", err_mark);

		err_mark = errors;
		run_frame(0, 8, 30);
		run_frame(0, 0, 30);
		finish_test("idle gaps", err_mark);

		err_mark = errors;
		req_width     = new_width;
		req_highlight = $urandom();
		run_frame(0, 8, 10);                        // Settings load at its last beat
		run_frame(0, 8, 10);
		run_frame(0, 0, 10);
		finish_test("width and colour change", err_mark);

		assert (exp_q.size() == 0) else begin
			$display("%0d expected output beats never appeared", exp_q.size());
			errors++;
		end
		assert_fails = bbox_highlight_top_inst.bbox_highlight_asserts_inst.fail_count;
		$display("Tests run %0d, failed %0d, pixel checks %0d, errors %0d, assertion fails %0d",
			tests_run, tests_failed, checks, errors, assert_fails);
		if (errors == 0 && tests_failed == 0 && assert_fails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule : bbox_highlight_tb

/* verilog/bbox_accumulator.sv */
/*
 * Motion box accumulator
 * Write bank grows the min/max box over the motion pixels of a frame,
 * read bank holds the box of the previous frame for the overlay
 */

`timescale 1ns/100ps

module bbox_accumulator
	import bbox_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     pixel_valid_i,               // Beat present
	input  logic     motion_i,                    // Motion flag of the beat
	input  logic     frame_end_i,                 // Last beat of the frame
	input  coord_x_t x_i,                         // Column of the beat
	input  coord_y_t y_i,                         // Row of the beat
	output logic     box_active_o,                // Published box holds motion
	output coord_x_t box_min_x_o,
	output coord_x_t box_max_x_o,
	output coord_y_t box_min_y_o,
	output coord_y_t box_max_y_o
);

	box_state_t state;                              // Write bank state
	coord_x_t   wr_min_x, wr_max_x;                 // Write bank bounds
	coord_y_t   wr_min_y, wr_max_y;
	coord_x_t   nxt_min_x, nxt_max_x;               // Bounds including this beat
	coord_y_t   nxt_min_y, nxt_max_y;
	logic       hit;                                // Motion pixel this cycle
	logic       nxt_active;                         // Box non-empty after this beat

	assign hit = pixel_valid_i & motion_i;
	assign nxt_active = (state == BOX_OPEN) | hit;

	// ------------------------------------------------------------------------
	// Merge of the write bank with the current pixel
	// ------------------------------------------------------------------------
	always_comb begin
		nxt_min_x = wr_min_x;
		nxt_max_x = wr_max_x;
		nxt_min_y = wr_min_y;
		nxt_max_y = wr_max_y;
		if (hit) begin
			if (state == BOX_EMPTY) begin       // First pixel sets all bounds
				nxt_min_x = x_i;
				nxt_max_x = x_i;
				nxt_min_y = y_i;
				nxt_max_y = y_i;
			end else begin                      // Widen as needed
				if (x_i < wr_min_x) nxt_min_x = x_i;
				if (x_i > wr_max_x) nxt_max_x = x_i;
				if (y_i < wr_min_y) nxt_min_y = y_i;
				if (y_i > wr_max_y) nxt_max_y = y_i;
			end
		end
	end

	// Write bank state, back to empty at every frame boundary
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= BOX_EMPTY;
		else if (frame_end_i)
			state <= BOX_EMPTY;
		else if (hit)
			state <= BOX_OPEN;
	end

	// Write bank bounds, meaningful only while state is open
	always_ff @(posedge clk) begin
		if (hit) begin
			wr_min_x <= nxt_min_x;
			wr_max_x <= nxt_max_x;
			wr_min_y <= nxt_min_y;
			wr_max_y <= nxt_max_y;
		end
	end

	// ------------------------------------------------------------------------
	// Read bank, published on the frame-end edge
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			box_active_o <= 1'b0;                 // No box until a frame completes
		else if (frame_end_i)
			box_active_o <= nxt_active;
	end

	always_ff @(posedge clk) begin
		if (frame_end_i) begin                  // Includes the final beat
			box_min_x_o <= nxt_min_x;
			box_max_x_o <= nxt_max_x;
			box_min_y_o <= nxt_min_y;
			box_max_y_o <= nxt_max_y;
		end
	end

endmodule : bbox_accumulator

/* verilog/bbox_highlight_top.sv */
/*
 * Motion bounding box highlight, top level
 * Coordinate counter, frame configuration, box accumulator and
 * outline overlay on one valid-only pixel stream
 */

`timescale 1ns/100ps

module bbox_highlight_top
	import bbox_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     pixel_valid_i,               // Input beat
	input  logic     motion_i,                    // Motion flag
	input  logic     last_i,                      // Last beat of frame
	input  pixel_t   rgb_i,                       // Input pixel
	input  coord_x_t width_i,                     // Line width, taken at frame end
	input  pixel_t   highlight_i,                 // Colour, taken at frame end
	output pixel_t   pixel_o,                     // Output pixel
	output logic     pixel_valid_o                // Output beat
);

	coord_x_t x;                                    // Column of current beat
	coord_y_t y;                                    // Row of current beat
	logic     frame_end;                            // Valid last beat
	coord_x_t line_width;                           // Active width
	pixel_t   highlight;                            // Active colour
	logic     box_active;                           // Published box
	coord_x_t box_min_x, box_max_x;
	coord_y_t box_min_y, box_max_y;

	// ------------------------------------------------------------------------
	// Raster position
	// ------------------------------------------------------------------------
	pixel_coord_counter pixel_coord_counter_inst (
		.clk           (clk),
		.rst           (rst),
		.pixel_valid_i (pixel_valid_i),
		.last_i        (last_i),
		.line_width_i  (line_width),
		.x_o           (x),
		.y_o           (y),
		.frame_end_o   (frame_end)
	);

	// Settings swap only between frames
	frame_config frame_config_inst (
		.clk          (clk),
		.rst          (rst),
		.frame_end_i  (frame_end),
		.width_i      (width_i),
		.highlight_i  (highlight_i),
		.line_width_o (line_width),
		.highlight_o  (highlight)
	);

	// ------------------------------------------------------------------------
	// Box of frame k, used during frame k+1
	// ------------------------------------------------------------------------
	bbox_accumulator bbox_accumulator_inst (
		.clk           (clk),
		.rst           (rst),
		.pixel_valid_i (pixel_valid_i),
		.motion_i      (motion_i),
		.frame_end_i   (frame_end),
		.x_i           (x),
		.y_i           (y),
		.box_active_o  (box_active),
		.box_min_x_o   (box_min_x),
		.box_max_x_o   (box_max_x),
		.box_min_y_o   (box_min_y),
		.box_max_y_o   (box_max_y)
	);

	bbox_overlay bbox_overlay_inst (
		.clk           (clk),
		.rst           (rst),
		.pixel_valid_i (pixel_valid_i),
		.rgb_i         (rgb_i),
		.x_i           (x),
		.y_i           (y),
		.highlight_i   (highlight),
		.box_active_i  (box_active),
		.box_min_x_i   (box_min_x),
		.box_max_x_i   (box_max_x),
		.box_min_y_i   (box_min_y),
		.box_max_y_i   (box_max_y),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o)
	);

endmodule : bbox_highlight_top

/* verilog/bbox_overlay.sv */
/*
 * Box outline overlay
 * Replaces pixels on the outline of the published box with the
 * highlight colour, one register stage from input to output
 */

`timescale 1ns/100ps

module bbox_overlay
	import bbox_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     pixel_valid_i,               // Beat present
	input  pixel_t   rgb_i,                       // Incoming pixel
	input  coord_x_t x_i,                         // Column of the beat
	input  coord_y_t y_i,                         // Row of the beat
	input  pixel_t   highlight_i,                 // Outline colour
	input  logic     box_active_i,                // Published box valid
	input  coord_x_t box_min_x_i,
	input  coord_x_t box_max_x_i,
	input  coord_y_t box_min_y_i,
	input  coord_y_t box_max_y_i,
	output pixel_t   pixel_o,                     // Outgoing pixel
	output logic     pixel_valid_o                // Outgoing beat present
);

	logic in_x;                                     // Column within box span
	logic in_y;                                     // Row within box span
	logic on_vert;                                  // Left or right side
	logic on_horz;                                  // Top or bottom side
	logic on_edge;                                  // Pixel sits on the outline

	// ------------------------------------------------------------------------
	// Edge test
	// ------------------------------------------------------------------------
	assign in_x = (x_i >= box_min_x_i) && (x_i <= box_max_x_i);
	assign in_y = (y_i >= box_min_y_i) && (y_i <= box_max_y_i);

	assign on_vert = ((x_i == box_min_x_i) || (x_i == box_max_x_i)) && in_y;
	assign on_horz = ((y_i == box_min_y_i) || (y_i == box_max_y_i)) && in_x;

	// Inactive box masks stale bounds
	assign on_edge = box_active_i & (on_vert | on_horz);

	// ------------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pixel_o       <= '0;
			pixel_valid_o <= 1'b0;
		end else begin
			pixel_valid_o <= pixel_valid_i;       // Low after an idle cycle
			if (pixel_valid_i)                    // Hold last pixel over gaps
				pixel_o <= on_edge ? highlight_i : rgb_i;
		end
	end

endmodule : bbox_overlay

/* verilog/bbox_pkg.sv */
/*
 * Bounding box overlay, shared definitions
 * Coordinate and pixel widths, their vector types, the write bank
 * state encoding and the configuration used out of reset
 */

package bbox_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int COORD_X_BITS = 11;                 // Column index, up to 2048 wide
	localparam int COORD_Y_BITS = 10;                 // Row index, up to 1024 rows
	localparam int PIXEL_BITS   = 32;                 // Packed RGB word

	// Column index, also used for the line width
	typedef logic [COORD_X_BITS-1:0] coord_x_t;

	// Row index
	typedef logic [COORD_Y_BITS-1:0] coord_y_t;

	// Pixel value or highlight colour
	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// ------------------------------------------------------------------------
	// Defaults after reset
	// ------------------------------------------------------------------------
	localparam coord_x_t DEFAULT_WIDTH     = coord_x_t'(16);  // Small test raster
	localparam pixel_t   DEFAULT_HIGHLIGHT = 32'hFF000000;    // Alpha byte only

	// ------------------------------------------------------------------------
	// Write bank accumulation state
	// ------------------------------------------------------------------------
	typedef enum logic {
		BOX_EMPTY = 1'b0,                             // No motion seen this frame
		BOX_OPEN  = 1'b1                              // Bounds hold at least one pixel
	} box_state_t;

endpackage : bbox_pkg

/* verilog/frame_config.sv */
/*
 * Frame configuration shadow registers
 * Line width and highlight colour are taken from the inputs only on
 * the last beat of a frame, so one frame never sees them change
 */

`timescale 1ns/100ps

module frame_config
	import bbox_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     frame_end_i,                 // Last beat of the frame
	input  coord_x_t width_i,                     // Requested line width
	input  pixel_t   highlight_i,                 // Requested highlight colour
	output coord_x_t line_width_o,                // Width in force this frame
	output pixel_t   highlight_o                  // Colour in force this frame
);

	coord_x_t width_q;                              // Shadow of width_i
	pixel_t   highlight_q;                          // Shadow of highlight_i

	// ------------------------------------------------------------------------
	// Shadow load
	// New values apply from the beat after the frame-end beat
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			width_q     <= DEFAULT_WIDTH;         // Package defaults
			highlight_q <= DEFAULT_HIGHLIGHT;
		end else if (frame_end_i) begin
			width_q     <= width_i;
			highlight_q <= highlight_i;
		end
	end

	// Counter wraps with this width
	assign line_width_o = width_q;

	// Overlay paints with this colour
	assign highlight_o = highlight_q;

endmodule : frame_config

/* verilog/pixel_coord_counter.sv */
/*
 * Raster coordinate generator
 * Tracks column and row of the current beat, wraps the column at the
 * active line width and flags the last beat of a frame
 */

`timescale 1ns/100ps

module pixel_coord_counter
	import bbox_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     pixel_valid_i,               // Beat present
	input  logic     last_i,                      // Last beat of the frame
	input  coord_x_t line_width_i,                // Active line width
	output coord_x_t x_o,                         // Column of current beat
	output coord_y_t y_o,                         // Row of current beat
	output logic     frame_end_o                  // Valid beat carrying last
);

	logic     eol;                                  // Beat sits in last column

	// Only place where valid and last meet
	assign frame_end_o = pixel_valid_i & last_i;

	// Last column of the row
	assign eol = (x_o == coord_x_t'(line_width_i - 1'b1));

	// ------------------------------------------------------------------------
	// Counters advance on the edge that ends a beat, idle cycles hold
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x_o <= '0;
			y_o <= '0;
		end else if (frame_end_o) begin         // Frame done, back to origin
			x_o <= '0;
			y_o <= '0;
		end else if (pixel_valid_i) begin
			if (eol) begin                      // Wrap to next row
				x_o <= '0;
				y_o <= y_o + 1'b1;
			end else begin
				x_o <= x_o + 1'b1;
			end
		end
	end

endmodule : pixel_coord_counter
